//--- common/csr_pkg.sv
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [1:0]  plv_t;
    typedef logic [12:0] int_vec_t;
    typedef logic [7:0]  hw_int_t;

    // software write from the pipeline
    typedef struct packed {
        logic      we;
        csr_addr_t waddr;
        csr_data_t wmask;
        csr_data_t wdata;
    } csr_wr_t;

    typedef struct packed {
        logic      ex_en;     // one-cycle pulse
        ecode_t    ecode;
        logic      esubcode;
        csr_data_t pc;
    } exc_req_t;

    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    localparam ecode_t ECODE_INT  = 6'h00;
    localparam ecode_t ECODE_SYS  = 6'h0b;
    localparam ecode_t ECODE_BRK  = 6'h0c;
    localparam ecode_t ECODE_INE  = 6'h0d;
    localparam ecode_t ECODE_TLBR = 6'h3f;

    // field positions
    localparam int CRMD_PLV_LSB     = 0;
    localparam int CRMD_IE          = 2;
    localparam int CRMD_DA          = 3;
    localparam int CRMD_PG          = 4;
    localparam int PRMD_PPLV_LSB    = 0;
    localparam int PRMD_PIE         = 2;
    localparam int ESTAT_ECODE_LSB  = 16;
    localparam int ESTAT_ESUB_LSB   = 22;
    localparam int TCFG_EN          = 0;
    localparam int TCFG_PERIODIC    = 1;
    localparam int TCFG_INITVAL_LSB = 2;
    localparam int TI_BIT           = 11;
    localparam int IS_HW_LSB        = 2;

    localparam csr_data_t CRMD_RESET = 32'h0000_0008;  // DA=1

    // writable fields per register
    localparam csr_data_t CRMD_WMASK   = 32'h0000_01ff;
    localparam csr_data_t PRMD_WMASK   = 32'h0000_0007;
    localparam csr_data_t ECFG_WMASK   = 32'h0000_1bff;  // bit 10 reserved
    localparam csr_data_t ESTAT_WMASK  = 32'h0000_0003;  // software interrupts only
    localparam csr_data_t ERA_WMASK    = 32'hffff_ffff;
    localparam csr_data_t EENTRY_WMASK = 32'hffff_ffc0;
    localparam csr_data_t SAVE_WMASK   = 32'hffff_ffff;
    localparam csr_data_t TID_WMASK    = 32'hffff_ffff;
    localparam csr_data_t TCFG_WMASK   = 32'hffff_ffff;

    // masked merge, limited to the writable fields
    function automatic csr_data_t csr_merge(csr_data_t old, csr_wr_t w, csr_data_t fields);
        csr_data_t m;
        m = w.wmask & fields;
        return (w.wdata & m) | (old & ~m);
    endfunction

    function automatic csr_data_t low_mask(int unsigned width);
        return csr_data_t'((64'd1 << width) - 64'd1);
    endfunction

endpackage

//--- csr_top.f
+incdir+tests
common/csr_pkg.sv
except/csr_except.sv
timer/csr_timer.sv
verilog/csr_read_int.sv
verilog/csr_top.sv
tests/csr_tb.sv

//--- except/csr_except.sv
`timescale 1ns/1ps

module csr_except (
    input  logic                clk,
    input  logic                rstn,
    input  csr_pkg::csr_wr_t    wr,
    input  csr_pkg::exc_req_t   exc,
    input  logic                ertn_flush,
    input  csr_pkg::hw_int_t    hw_int,
    output csr_pkg::csr_data_t  crmd,
    output csr_pkg::csr_data_t  prmd,
    output csr_pkg::csr_data_t  ecfg,
    output csr_pkg::csr_data_t  estat_low,
    output csr_pkg::csr_data_t  era,
    output csr_pkg::csr_data_t  eentry,
    output csr_pkg::csr_data_t  save0,
    output csr_pkg::csr_data_t  save1,
    output csr_pkg::csr_data_t  save2,
    output csr_pkg::csr_data_t  save3,
    output csr_pkg::csr_data_t  new_pc
);
    import csr_pkg::*;

    csr_data_t crmd_q;
    csr_data_t prmd_q;
    csr_data_t ecfg_q;
    csr_data_t estat_q;
    csr_data_t era_q;
    csr_data_t eentry_q;
    csr_data_t save_q [4];
    csr_data_t estat_wr;
    logic      in_ex;
    logic      ret_skip;
    ecode_t    cur_ecode;
    plv_t      cur_plv;
    plv_t      prev_plv;

    logic crmd_we;
    logic prmd_we;
    logic ecfg_we;
    logic estat_we;
    logic era_we;
    logic eentry_we;

    assign crmd_we   = wr.we && (wr.waddr == CSR_CRMD);
    assign prmd_we   = wr.we && (wr.waddr == CSR_PRMD);
    assign ecfg_we   = wr.we && (wr.waddr == CSR_ECFG);
    assign estat_we  = wr.we && (wr.waddr == CSR_ESTAT);
    assign era_we    = wr.we && (wr.waddr == CSR_ERA);
    assign eentry_we = wr.we && (wr.waddr == CSR_EENTRY);

    assign cur_ecode = estat_q[ESTAT_ECODE_LSB +: $bits(ecode_t)];
    assign cur_plv   = crmd_q[CRMD_PLV_LSB +: $bits(plv_t)];
    assign prev_plv  = prmd_q[PRMD_PPLV_LSB +: $bits(plv_t)];
    assign estat_wr  = csr_merge(estat_q, wr, ESTAT_WMASK);

    // exception entry beats ertn, ertn beats a software write
    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd_q <= CRMD_RESET;
        end else if (exc.ex_en) begin
            crmd_q[CRMD_PLV_LSB +: $bits(plv_t)] <= '0;
            crmd_q[CRMD_IE]                      <= 1'b0;
            if (exc.ecode == ECODE_TLBR) begin  // refill runs in direct mode
                crmd_q[CRMD_DA] <= 1'b1;
                crmd_q[CRMD_PG] <= 1'b0;
            end
        end else if (ertn_flush) begin
            crmd_q[CRMD_PLV_LSB +: $bits(plv_t)] <= prev_plv;
            crmd_q[CRMD_IE]                      <= prmd_q[PRMD_PIE];
            if (cur_ecode == ECODE_TLBR) begin
                crmd_q[CRMD_DA] <= 1'b0;
                crmd_q[CRMD_PG] <= 1'b1;
            end
        end else if (crmd_we) begin
            crmd_q <= csr_merge(crmd_q, wr, CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prmd_q <= '0;
        end else if (exc.ex_en) begin
            prmd_q[PRMD_PPLV_LSB +: $bits(plv_t)] <= cur_plv;
            prmd_q[PRMD_PIE]                      <= crmd_q[CRMD_IE];
        end else if (prmd_we) begin
            prmd_q <= csr_merge(prmd_q, wr, PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            estat_q <= '0;
        end else begin
            if (exc.ex_en) begin
                estat_q[ESTAT_ECODE_LSB +: $bits(ecode_t)] <= exc.ecode;
                estat_q[ESTAT_ESUB_LSB +: 9]               <= {8'b0, exc.esubcode};
            end else if (estat_we) begin
                estat_q[1:0] <= estat_wr[1:0];
            end
            estat_q[IS_HW_LSB +: $bits(hw_int_t)] <= hw_int;  // sampled every cycle
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecfg_q   <= '0;
            era_q    <= '0;
            eentry_q <= '0;
        end else begin
            if (ecfg_we) begin
                ecfg_q <= csr_merge(ecfg_q, wr, ECFG_WMASK);
            end
            if (exc.ex_en) begin
                era_q <= exc.pc;
            end else if (era_we) begin
                era_q <= csr_merge(era_q, wr, ERA_WMASK);
            end
            if (eentry_we) begin
                eentry_q <= csr_merge(eentry_q, wr, EENTRY_WMASK);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr.we && (wr.waddr == CSR_SAVE0 + csr_addr_t'(i))) begin
                    save_q[i] <= csr_merge(save_q[i], wr, SAVE_WMASK);
                end
            end
        end
    end

    // ertn without a pending exception returns to ERA as is
    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_ex <= 1'b0;
        end else if (exc.ex_en) begin
            in_ex <= 1'b1;
        end else if (ertn_flush) begin
            in_ex <= 1'b0;
        end
    end

    assign ret_skip = in_ex && (cur_ecode == ECODE_SYS || cur_ecode == ECODE_BRK ||
                                cur_ecode == ECODE_INE || cur_ecode == ECODE_INT);
    assign new_pc   = ret_skip ? era_q + 32'd4 : era_q;  // skip the trapping instruction

    assign crmd      = crmd_q;
    assign prmd      = prmd_q;
    assign ecfg      = ecfg_q;
    assign estat_low = estat_q;
    assign era       = era_q;
    assign eentry    = eentry_q;
    assign save0     = save_q[0];
    assign save1     = save_q[1];
    assign save2     = save_q[2];
    assign save3     = save_q[3];

    // the pipeline never reports an exception and an ertn together
    a_no_ex_ertn: assert property (@(posedge clk) disable iff (!rstn)
        !(exc.ex_en && ertn_flush))
        else $error("ex_en and ertn_flush high in the same cycle");

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the CSR testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module csr_tb -f csr_top.f -o csr_sim \
    && ./obj_dir/csr_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

exit 0

//--- tests/csr_tb_ref.svh
`ifndef CSR_TB_REF_SVH
`define CSR_TB_REF_SVH

// shadow copies of the DUT registers
csr_data_t sh_crmd;
csr_data_t sh_prmd;
csr_data_t sh_ecfg;
csr_data_t sh_estat;  // timer bit kept apart in sh_ti
csr_data_t sh_era;
csr_data_t sh_eentry;
csr_data_t sh_save [4];
csr_data_t sh_tid;
csr_data_t sh_tcfg;
csr_data_t sh_tval;
logic      sh_ti;
logic      sh_in_ex;

function automatic void reset_shadow();
    sh_crmd   = CRMD_RESET;
    sh_prmd   = '0;
    sh_ecfg   = '0;
    sh_estat  = '0;
    sh_era    = '0;
    sh_eentry = '0;
    foreach (sh_save[i]) sh_save[i] = '0;
    sh_tid    = CORE_ID;
    sh_tcfg   = '0;
    sh_tval   = '1;
    sh_ti     = 1'b0;
    sh_in_ex  = 1'b0;
endfunction

// only bits both in the write mask and in the field mask change
function automatic csr_data_t merge_ref(csr_data_t old, csr_data_t mask, csr_data_t data,
                                       csr_data_t fields);
    csr_data_t sel;
    sel = mask & fields;
    return (old & ~sel) | (data & sel);
endfunction

function automatic void apply_write(csr_addr_t addr, csr_data_t mask, csr_data_t data);
    case (addr)
        CSR_CRMD:   sh_crmd   = merge_ref(sh_crmd, mask, data, CRMD_WMASK);
        CSR_PRMD:   sh_prmd   = merge_ref(sh_prmd, mask, data, PRMD_WMASK);
        CSR_ECFG:   sh_ecfg   = merge_ref(sh_ecfg, mask, data, ECFG_WMASK);
        CSR_ESTAT:  sh_estat  = merge_ref(sh_estat, mask, data, ESTAT_WMASK);
        CSR_ERA:    sh_era    = merge_ref(sh_era, mask, data, ERA_WMASK);
        CSR_EENTRY: sh_eentry = merge_ref(sh_eentry, mask, data, EENTRY_WMASK);
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
            sh_save[addr[1:0]] = merge_ref(sh_save[addr[1:0]], mask, data, SAVE_WMASK);
        CSR_TID:    sh_tid    = merge_ref(sh_tid, mask, data, TID_WMASK);
        CSR_TCFG:   sh_tcfg   = merge_ref(sh_tcfg, mask, data, TCFG_WMASK & TMR_MASK);
        CSR_TICLR:  if (data[0]) sh_ti = 1'b0;  // mask not used here
        default:    ;
    endcase
endfunction

function automatic csr_data_t expected_read(csr_addr_t addr);
    case (addr)
        CSR_CRMD:   return sh_crmd;
        CSR_PRMD:   return sh_prmd;
        CSR_ECFG:   return sh_ecfg;
        CSR_ESTAT:  return sh_estat | (csr_data_t'(sh_ti) << TI_BIT);
        CSR_ERA:    return sh_era;
        CSR_EENTRY: return sh_eentry;
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return sh_save[addr[1:0]];
        CSR_TID:    return sh_tid;
        CSR_TCFG:   return sh_tcfg & TMR_MASK;
        CSR_TVAL:   return sh_tval & TMR_MASK;
        default:    return '0;
    endcase
endfunction

function automatic logic expected_int();
    csr_data_t pend;
    pend = sh_ecfg & expected_read(CSR_ESTAT);
    return (|pend[12:0]) && sh_crmd[CRMD_IE];
endfunction

// skip the trapping instruction for syscall, break, ine and interrupt
function automatic csr_data_t expected_ret_pc();
    ecode_t code;
    code = sh_estat[ESTAT_ECODE_LSB +: 6];
    if (sh_in_ex && (code == ECODE_SYS || code == ECODE_BRK ||
                     code == ECODE_INE || code == ECODE_INT)) begin
        return sh_era + 32'd4;
    end
    return sh_era;
endfunction

`endif

//--- tests/csr_tb.sv
`timescale 1ns/1ps

module csr_tb;
    import csr_pkg::*;

    localparam csr_data_t CORE_ID  = 32'h0000_0002;
    localparam int        TIMER_W  = 32;
    localparam csr_data_t TMR_MASK = csr_data_t'((64'd1 << TIMER_W) - 64'd1);
    localparam int        INIT     = 5;  // timer initial value in units of 4 cycles
    localparam int        LATENCY  = 4 * INIT + 1;

    logic      clk;
    logic      rstn;
    csr_wr_t   wr;
    csr_addr_t raddr;
    exc_req_t  exc;
    logic      ertn_flush;
    hw_int_t   hw_int;
    csr_data_t rdata;
    logic      has_int;
    csr_data_t new_pc;
    csr_data_t ex_entry_pc;
    integer    seed;
    logic      checking;
    int        waited;
    csr_addr_t kept_addrs [15];
    csr_addr_t wr_addrs [8];
    ecode_t    ex_codes [6];

    `include "csr_tb_ref.svh"

    csr_top #(.CORE_ID(CORE_ID), .TIMER_W(TIMER_W)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_stop(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // advance one clock and land the hw lines in the shadow ESTAT
    task automatic step();
        hw_int_t sampled;
        sampled = hw_int;
        @(posedge clk);
        sh_estat[IS_HW_LSB +: $bits(hw_int_t)] = sampled;
        #2;
    endtask

    task automatic csr_write(input csr_addr_t addr, input csr_data_t mask, input csr_data_t data);
        wr.we    = 1'b1;
        wr.waddr = addr;
        wr.wmask = mask;
        wr.wdata = data;
        step();
        wr.we = 1'b0;
        apply_write(addr, mask, data);
    endtask

    task automatic read_check(input csr_addr_t addr);
        raddr = addr;
        #1;
        check_data($sformatf("rdata[%h]", addr), rdata, expected_read(addr));
    endtask

    task automatic raise_exception(input ecode_t code, input csr_data_t pc, input logic sub);
        exc.ex_en    = 1'b1;
        exc.ecode    = code;
        exc.esubcode = sub;
        exc.pc       = pc;
        step();
        exc.ex_en = 1'b0;
        sh_prmd[2:0] = sh_crmd[2:0];  // old plv and ie
        sh_crmd[2:0] = '0;
        if (code == ECODE_TLBR) sh_crmd[CRMD_PG:CRMD_DA] = 2'b01;
        sh_estat[ESTAT_ECODE_LSB +: 6] = code;
        sh_estat[ESTAT_ESUB_LSB +: 9]  = {8'b0, sub};
        sh_era   = pc;
        sh_in_ex = 1'b1;
    endtask

    task automatic return_ertn();
        ertn_flush = 1'b1;
        step();
        ertn_flush = 1'b0;
        sh_crmd[2:0] = sh_prmd[2:0];
        if (sh_estat[ESTAT_ECODE_LSB +: 6] == ECODE_TLBR) sh_crmd[CRMD_PG:CRMD_DA] = 2'b10;
        sh_in_ex = 1'b0;
    endtask

    task automatic wait_has_int(input int limit, input string what);
        waited = 0;
        while (!has_int) begin
            if (waited >= limit) fail_stop({"has_int did not rise ", what});
            step();
            waited++;
        end
    endtask

    task automatic hold_no_int(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            step();
            check_bit("has_int", has_int, expected_int());
        end
    endtask

    // return address and vector base checked on every cycle
    always @(negedge clk) begin
        if (checking) begin
            check_data("new_pc", new_pc, expected_ret_pc());
            check_data("ex_entry_pc", ex_entry_pc, sh_eentry);
        end
    end

    initial begin
        seed       = 32'h8b25;
        checking   = 1'b0;
        rstn       = 1'b0;
        wr         = '0;
        raddr      = '0;
        exc        = '0;
        ertn_flush = 1'b0;
        hw_int     = '0;
        kept_addrs = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_EENTRY,
                       CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_TCFG,
                       CSR_TVAL, CSR_TICLR, 14'h002};
        wr_addrs   = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                       CSR_ECFG, CSR_ERA, CSR_EENTRY, CSR_CRMD};
        ex_codes   = '{ECODE_INT, ECODE_SYS, ECODE_BRK, ECODE_INE, ECODE_TLBR, 6'h08};
        reset_shadow();
        repeat (3) @(posedge clk);
        #2;
        rstn     = 1'b1;
        checking = 1'b1;

        foreach (kept_addrs[i]) read_check(kept_addrs[i]);
        check_bit("has_int", has_int, 1'b0);

        for (int n = 0; n < 24; n++) begin
            csr_addr_t a;
            a = wr_addrs[$unsigned($random(seed)) % 8];
            csr_write(a, $random(seed), $random(seed));
            read_check(a);
            check_bit("has_int", has_int, expected_int());
        end

        for (int n = 0; n < 10; n++) begin
            csr_write(CSR_CRMD, 32'h7, $random(seed));  // random plv and ie
            raise_exception(ex_codes[$unsigned($random(seed)) % 6], $random(seed),
                            $random(seed) & 1);
            read_check(CSR_CRMD);
            read_check(CSR_PRMD);
            read_check(CSR_ESTAT);
            read_check(CSR_ERA);
            check_data("new_pc", new_pc, expected_ret_pc());
            return_ertn();
            read_check(CSR_CRMD);
            check_data("new_pc", new_pc, expected_ret_pc());
        end

        csr_write(CSR_ECFG, '1, 32'h0000_03fc);  // all hw lines
        for (int n = 0; n < 8; n++) begin
            csr_write(CSR_CRMD, 32'h4, $random(seed));
            hw_int = hw_int_t'($random(seed));
            read_check(CSR_ESTAT);
            step();
            read_check(CSR_ESTAT);
            check_bit("has_int", has_int, expected_int());
        end
        hw_int = '0;
        step();

        csr_write(CSR_ECFG, '1, 32'h1 << TI_BIT);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        csr_write(CSR_TCFG, '1, csr_data_t'(INIT * 4 + 3));  // periodic and enabled
        read_check(CSR_TCFG);
        wait_has_int(2 * LATENCY, "after the periodic TCFG write");
        check_data("timer latency", csr_data_t'(waited), csr_data_t'(LATENCY));
        sh_ti = 1'b1;
        read_check(CSR_ESTAT);
        csr_write(CSR_TICLR, '1, 32'h1);
        check_bit("has_int", has_int, expected_int());
        read_check(CSR_ESTAT);
        wait_has_int(2 * LATENCY, "again in periodic mode");
        sh_ti = 1'b1;
        csr_write(CSR_TICLR, '1, 32'h1);

        csr_write(CSR_TCFG, '1, csr_data_t'(INIT * 4 + 1));  // one-shot
        wait_has_int(2 * LATENCY, "after the one-shot TCFG write");
        check_data("timer latency", csr_data_t'(waited), csr_data_t'(LATENCY));
        sh_ti = 1'b1;
        csr_write(CSR_TICLR, '1, 32'h1);
        hold_no_int(3 * LATENCY);
        sh_tval = '1;  // stopped timer parks at all ones
        read_check(CSR_TVAL);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- timer/csr_timer.sv
`timescale 1ns/1ps

module csr_timer #(
    parameter csr_pkg::csr_data_t CORE_ID = '0,
    parameter int                 TIMER_W = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  csr_pkg::csr_wr_t    wr,
    output csr_pkg::csr_data_t  tid,
    output csr_pkg::csr_data_t  tcfg,
    output csr_pkg::csr_data_t  tval,
    output logic                ti_pending
);
    import csr_pkg::*;

    localparam csr_data_t TCFG_FIELDS = TCFG_WMASK & low_mask(TIMER_W);

    csr_data_t          tid_q;
    csr_data_t          tcfg_q;
    csr_data_t          tcfg_new;
    logic [TIMER_W-1:0] tval_q;
    logic [TIMER_W-1:0] tval_load;
    logic [TIMER_W-1:0] tval_reload;
    logic               timer_en;
    logic               tid_we;
    logic               tcfg_we;
    logic               ticlr_we;
    logic               tval_zero;

    assign tid_we    = wr.we && (wr.waddr == CSR_TID);
    assign tcfg_we   = wr.we && (wr.waddr == CSR_TCFG);
    assign ticlr_we  = wr.we && (wr.waddr == CSR_TICLR);
    assign tcfg_new  = csr_merge(tcfg_q, wr, TCFG_FIELDS);
    assign tval_zero = (tval_q == '0);

    // initial value is in units of 4 cycles
    assign tval_load   = {tcfg_new[TIMER_W-1:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};
    assign tval_reload = {tcfg_q[TIMER_W-1:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tid_q <= CORE_ID;
        end else if (tid_we) begin
            tid_q <= csr_merge(tid_q, wr, TID_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcfg_q   <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_we) begin
            tcfg_q   <= tcfg_new;
            timer_en <= tcfg_new[TCFG_EN];
        end else if (timer_en && tval_zero) begin
            timer_en <= tcfg_q[TCFG_PERIODIC];  // one-shot stops here
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval_q <= '1;
        end else if (tcfg_we && tcfg_new[TCFG_EN]) begin
            tval_q <= tval_load;
        end else if (timer_en) begin
            if (!tval_zero) begin
                tval_q <= tval_q - 1'b1;
            end else if (tcfg_q[TCFG_PERIODIC]) begin
                tval_q <= tval_reload;
            end else begin
                tval_q <= '1;
            end
        end
    end

    // clear wins over a new expiry
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ti_pending <= 1'b0;
        end else if (ticlr_we && wr.wdata[0]) begin
            ti_pending <= 1'b0;
        end else if (timer_en && tval_zero) begin
            ti_pending <= 1'b1;
        end
    end

    assign tid  = tid_q;
    assign tcfg = tcfg_q;
    assign tval = csr_data_t'(tval_q);

    a_tval_frozen: assert property (@(posedge clk) disable iff (!rstn)
        (!tcfg_q[TCFG_EN] && !tcfg_we) |=> $stable(tval_q))
        else $error("TVAL changed while the timer was disabled");

endmodule

//--- verilog/csr_read_int.sv
`timescale 1ns/1ps

module csr_read_int #(
    parameter int TIMER_W = 32
) (
    input  csr_pkg::csr_addr_t  raddr,
    input  csr_pkg::csr_data_t  crmd,
    input  csr_pkg::csr_data_t  prmd,
    input  csr_pkg::csr_data_t  ecfg,
    input  csr_pkg::csr_data_t  estat_low,
    input  csr_pkg::csr_data_t  era,
    input  csr_pkg::csr_data_t  eentry,
    input  csr_pkg::csr_data_t  save0,
    input  csr_pkg::csr_data_t  save1,
    input  csr_pkg::csr_data_t  save2,
    input  csr_pkg::csr_data_t  save3,
    input  csr_pkg::csr_data_t  tid,
    input  csr_pkg::csr_data_t  tcfg,
    input  csr_pkg::csr_data_t  tval,
    input  logic                ti_pending,
    output csr_pkg::csr_data_t  rdata,
    output logic                has_int
);
    import csr_pkg::*;

    localparam csr_data_t TIMER_MASK = low_mask(TIMER_W);

    csr_data_t estat;
    int_vec_t  int_lines;

    // timer pending bit lives in the timer block
    always_comb begin
        estat         = estat_low;
        estat[TI_BIT] = ti_pending;
    end

    always_comb begin
        case (raddr)
            CSR_CRMD:   rdata = crmd;
            CSR_PRMD:   rdata = prmd;
            CSR_ECFG:   rdata = ecfg;
            CSR_ESTAT:  rdata = estat;
            CSR_ERA:    rdata = era;
            CSR_EENTRY: rdata = eentry;
            CSR_SAVE0:  rdata = save0;
            CSR_SAVE1:  rdata = save1;
            CSR_SAVE2:  rdata = save2;
            CSR_SAVE3:  rdata = save3;
            CSR_TID:    rdata = tid;
            CSR_TCFG:   rdata = tcfg & TIMER_MASK;
            CSR_TVAL:   rdata = tval & TIMER_MASK;
            CSR_TICLR:  rdata = '0;  // write-only
            default:    rdata = '0;
        endcase
    end

    assign int_lines = ecfg[$bits(int_vec_t)-1:0] & estat[$bits(int_vec_t)-1:0];
    assign has_int   = (|int_lines) && crmd[CRMD_IE];

endmodule

//--- verilog/csr_top.sv
`timescale 1ns/1ps

module csr_top #(
    parameter csr_pkg::csr_data_t CORE_ID = 32'h0000_0000,
    parameter int                 TIMER_W = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  csr_pkg::csr_wr_t    wr,
    input  csr_pkg::csr_addr_t  raddr,
    input  csr_pkg::exc_req_t   exc,
    input  logic                ertn_flush,
    input  csr_pkg::hw_int_t    hw_int,
    output csr_pkg::csr_data_t  rdata,
    output logic                has_int,
    output csr_pkg::csr_data_t  new_pc,
    output csr_pkg::csr_data_t  ex_entry_pc
);
    import csr_pkg::*;

    csr_data_t crmd;
    csr_data_t prmd;
    csr_data_t ecfg;
    csr_data_t estat_low;
    csr_data_t era;
    csr_data_t eentry;
    csr_data_t save0;
    csr_data_t save1;
    csr_data_t save2;
    csr_data_t save3;
    csr_data_t tid;
    csr_data_t tcfg;
    csr_data_t tval;
    logic      ti_pending;

    csr_except i_except (
        .clk        (clk),
        .rstn       (rstn),
        .wr         (wr),
        .exc        (exc),
        .ertn_flush (ertn_flush),
        .hw_int     (hw_int),
        .crmd       (crmd),
        .prmd       (prmd),
        .ecfg       (ecfg),
        .estat_low  (estat_low),
        .era        (era),
        .eentry     (eentry),
        .save0      (save0),
        .save1      (save1),
        .save2      (save2),
        .save3      (save3),
        .new_pc     (new_pc)
    );

    csr_timer #(
        .CORE_ID (CORE_ID),
        .TIMER_W (TIMER_W)
    ) i_timer (
        .clk        (clk),
        .rstn       (rstn),
        .wr         (wr),
        .tid        (tid),
        .tcfg       (tcfg),
        .tval       (tval),
        .ti_pending (ti_pending)
    );

    csr_read_int #(
        .TIMER_W (TIMER_W)
    ) i_read_int (
        .raddr      (raddr),
        .crmd       (crmd),
        .prmd       (prmd),
        .ecfg       (ecfg),
        .estat_low  (estat_low),
        .era        (era),
        .eentry     (eentry),
        .save0      (save0),
        .save1      (save1),
        .save2      (save2),
        .save3      (save3),
        .tid        (tid),
        .tcfg       (tcfg),
        .tval       (tval),
        .ti_pending (ti_pending),
        .rdata      (rdata),
        .has_int    (has_int)
    );

    assign ex_entry_pc = eentry;  // exception vector base

endmodule
